//--- Makefile
# Verilator build and run of the turbo alpha testbench

VERILATOR ?= verilator
TOP       ?= turbo_alpha_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(filter %.sv,$(shell cat $(FILELIST))) $(wildcard dv/*.svh)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# passes only when the testbench prints its pass line
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'Test OK'

clean:
	rm -rf $(OBJ_DIR)

//--- build.f
+incdir+dv
source/turbo_pkg.sv
source/sys_parity_split.sv
source/branch_metric.sv
source/alpha_recursion.sv
source/turbo_alpha_top.sv
dv/turbo_alpha_tb.sv

//--- dv/turbo_alpha_stim.txt
// one 20-bit word each: tag nibble, then a 16-bit value
// tags 1 blklen, 2 a-priori, 3 input word, 4 branch1, 5 branch2, 6 alpha0..7, 7 block end, F stop

// block A, three steps
10003
// pair 1: sys 3, parity 1, a-priori still 0
30003
30001
40004 50002
60000 6FF7E 6FF7E 6FF80 6FFF8 6FF7E 6FF7E 6FF80 70000
// pair 2: sys -2, parity 5
3FFFE
30005
40003 5FFF9
60000 6FF82 6FFEE 6FF80 6FFFA 6FF84 6FFFC 6FF7E 70000
// a-priori 2 from pair 3 on
20002
// pair 3: sys 1, parity 1, ends block A
30001
30001
40004 50002
60000 6FFE8 6FFF8 6FFF4 6FFF8 6FFEC 6FFF4 6FFFC 70001

// block B, two steps, a-priori 2 still held
10002
// pair 4: sys 0, parity -2, restart from initial metrics
30000
3FFFE
40000 50004
60000 6FF84 6FF84 6FF80 60000 6FF84 6FF84 6FF80 70000
// pair 5: sys -1, parity 3, ends block B
3FFFF
30003
40004 5FFFE
60000 6FF82 6FFFA 6FF80 6FFF8 6FF7E 6FFFE 6FF84 70001

// block C, one step per block
10001
2FFFD
// pair 6: sys 5, parity 2, a-priori -3
30005
30002
40004 50000
60000 6FF7C 6FF7C 6FF80 6FFF8 6FF7C 6FF7C 6FF80 70001
// pair 7: sys 0, parity 0
30000
30000
4FFFD 5FFFD
60000 6FF86 6FF86 6FF86 60006 6FF86 6FF86 6FF86 70001

FFFFF

//--- dv/turbo_alpha_checks.svh
`ifndef TURBO_ALPHA_CHECKS_SVH
`define TURBO_ALPHA_CHECKS_SVH

//////////////////////////////////////////////////////////////////////
// result comparison
//////////////////////////////////////////////////////////////////////

// first failure ends the run
task automatic stop_on_error(input string line);
    $display("%s", line);
    $display("Test FAILED");
    $fatal(1);
endtask

task automatic compare_metric(
    input string              name,
    input turbo_pkg::metric_t expected,
    input turbo_pkg::metric_t actual
);
    if (actual !== expected) begin
        stop_on_error($sformatf("Error: %s expected %h actual %h", name, expected, actual));
    end
endtask

task automatic compare_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
        stop_on_error($sformatf("Error: %s expected %b actual %b", name, expected, actual));
    end
endtask

// strobe position in clock cycles
task automatic compare_cycle(input string name, input int expected, input int actual);
    if (actual != expected) begin
        stop_on_error($sformatf("Error: %s expected cycle %0d actual cycle %0d",
                                name, expected, actual));
    end
endtask

//////////////////////////////////////////////////////////////////////
// bounded waits
//////////////////////////////////////////////////////////////////////

// until every accepted pair has produced its alpha step
task automatic wait_pipeline_empty(input int limit, input string what);
    int waited;
    waited = 0;
    while (al_pending.size() != 0) begin
        if (waited >= limit) begin
            stop_on_error($sformatf("Timed out after %0d cycles waiting for %s", limit, what));
        end else begin
            @(posedge clk);
            waited++;
        end
    end
endtask

`endif

//--- dv/turbo_alpha_tb.sv
`timescale 1ns/10ps
`default_nettype none

module turbo_alpha_tb;

    localparam int STIM_DEPTH = 256;

    logic               clk = 1'b0;
    logic               reset_i;
    turbo_pkg::metric_t data_i;
    logic               valid_i;
    turbo_pkg::metric_t apriori_i;
    logic               valid_apriori_i;
    turbo_pkg::blklen_t blklen_i;
    turbo_pkg::metric_t branch1_o;
    turbo_pkg::metric_t branch2_o;
    logic               branch_valid_o;
    turbo_pkg::metric_t alpha_out [turbo_pkg::N_STATES];
    logic               alpha_valid_o;
    logic               block_end_o;

    logic [19:0]        stim_mem [STIM_DEPTH];
    logic [15:0]        lfsr_q = 16'd21;
    int                 cycle = 0;
    int                 pair_idx = 0;
    int                 step_idx = 0;
    // cycle in which each parity word was presented
    int                 br_pending [$];
    int                 al_pending [$];
    turbo_pkg::metric_t exp_b1 [$];
    turbo_pkg::metric_t exp_b2 [$];
    turbo_pkg::metric_t exp_alpha [$];
    logic               exp_end [$];

    `include "turbo_alpha_checks.svh"

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    turbo_alpha_top turbo_alpha_top_inst (
        .clk             (clk),
        .reset_i         (reset_i),
        .data_i          (data_i),
        .valid_i         (valid_i),
        .apriori_i       (apriori_i),
        .valid_apriori_i (valid_apriori_i),
        .blklen_i        (blklen_i),
        .branch1_o       (branch1_o),
        .branch2_o       (branch2_o),
        .branch_valid_o  (branch_valid_o),
        .alpha0_o        (alpha_out[0]),
        .alpha1_o        (alpha_out[1]),
        .alpha2_o        (alpha_out[2]),
        .alpha3_o        (alpha_out[3]),
        .alpha4_o        (alpha_out[4]),
        .alpha5_o        (alpha_out[5]),
        .alpha6_o        (alpha_out[6]),
        .alpha7_o        (alpha_out[7]),
        .alpha_valid_o   (alpha_valid_o),
        .block_end_o     (block_end_o)
    );

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    // galois form, taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        logic [15:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ 16'hB400;
        end
        return next;
    endfunction

    // two bits give 0 to 3 idle cycles
    task automatic idle_gap();
        int gap;
        gap = 0;
        for (int b = 0; b < 2; b++) begin
            gap = gap * 2 + int'(lfsr_q[0]);
            lfsr_q = lfsr_next(lfsr_q);
        end
        repeat (gap) begin
            @(posedge clk);
            valid_i         <= 1'b0;
            valid_apriori_i <= 1'b0;
        end
    endtask

    task automatic drive_word(input turbo_pkg::metric_t word, input logic is_parity);
        @(posedge clk);
        valid_apriori_i <= 1'b0;
        data_i          <= word;
        valid_i         <= 1'b1;
        @(negedge clk);
        if (is_parity) begin
            br_pending.push_back(cycle);
            al_pending.push_back(cycle);
        end
    endtask

    task automatic drive_apriori(input turbo_pkg::metric_t word);
        @(posedge clk);
        valid_i         <= 1'b0;
        apriori_i       <= word;
        valid_apriori_i <= 1'b1;
        @(negedge clk);
    endtask

    // tags 4 to 7 hold expected values
    task automatic load_expected();
        for (int i = 0; i < STIM_DEPTH; i++) begin
            case (stim_mem[i][19:16])
                4'h4: exp_b1.push_back(stim_mem[i][15:0]);
                4'h5: exp_b2.push_back(stim_mem[i][15:0]);
                4'h6: exp_alpha.push_back(stim_mem[i][15:0]);
                4'h7: exp_end.push_back(stim_mem[i][0]);
                default: ;
            endcase
        end
    endtask

    task automatic run_stimulus();
        logic [19:0] rec;
        int          word_count;
        word_count = 0;
        for (int i = 0; i < STIM_DEPTH; i++) begin
            rec = stim_mem[i];
            if (rec[19:16] == 4'hF) begin
                break;
            end
            case (rec[19:16])
                4'h1: begin
                    // block length only changes between blocks
                    @(posedge clk);
                    valid_i         <= 1'b0;
                    valid_apriori_i <= 1'b0;
                    wait_pipeline_empty(20, "the block to drain before a length change");
                    blklen_i        <= rec[15:0];
                end
                4'h2: begin
                    idle_gap();
                    drive_apriori(rec[15:0]);
                end
                4'h3: begin
                    idle_gap();
                    drive_word(rec[15:0], (word_count % 2) == 1);
                    word_count++;
                end
                default: ;
            endcase
        end
        @(posedge clk);
        valid_i         <= 1'b0;
        valid_apriori_i <= 1'b0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // output monitor
    //////////////////////////////////////////////////////////////////////

    task automatic verify_branch_pair();
        int accepted;
        if (br_pending.size() == 0 || exp_b1.size() == 0 || exp_b2.size() == 0) begin
            stop_on_error("branch_valid_o went high with no pair in flight");
        end else begin
            accepted = br_pending.pop_front();
            compare_cycle($sformatf("pair %0d branch_valid_o", pair_idx), accepted + 2, cycle);
            compare_metric($sformatf("pair %0d branch1_o", pair_idx), exp_b1.pop_front(),
                           branch1_o);
            compare_metric($sformatf("pair %0d branch2_o", pair_idx), exp_b2.pop_front(),
                           branch2_o);
            pair_idx++;
        end
    endtask

    task automatic verify_alpha_step();
        int accepted;
        if (al_pending.size() == 0 || exp_alpha.size() < turbo_pkg::N_STATES ||
            exp_end.size() == 0) begin
            stop_on_error("alpha_valid_o went high with no pair in flight");
        end else begin
            accepted = al_pending.pop_front();
            compare_cycle($sformatf("step %0d alpha_valid_o", step_idx), accepted + 3, cycle);
            for (int s = 0; s < turbo_pkg::N_STATES; s++) begin
                compare_metric($sformatf("step %0d alpha%0d_o", step_idx, s),
                               exp_alpha.pop_front(), alpha_out[s]);
            end
            compare_flag($sformatf("step %0d block_end_o", step_idx), exp_end.pop_front(),
                         block_end_o);
            step_idx++;
        end
    endtask

    // sampled half a cycle after the driving edge
    always @(negedge clk) begin
        if (reset_i) begin
            compare_flag("reset branch_valid_o", 1'b0, branch_valid_o);
            compare_flag("reset alpha_valid_o", 1'b0, alpha_valid_o);
            compare_flag("reset block_end_o", 1'b0, block_end_o);
        end else begin
            if (branch_valid_o) begin
                verify_branch_pair();
            end
            if (alpha_valid_o) begin
                verify_alpha_step();
            end else if (block_end_o) begin
                stop_on_error("block_end_o went high without alpha_valid_o");
            end
        end
    end

    initial begin
        reset_i         <= 1'b1;
        data_i          <= '0;
        valid_i         <= 1'b0;
        apriori_i       <= '0;
        valid_apriori_i <= 1'b0;
        blklen_i        <= 16'd1;
        $readmemh("dv/turbo_alpha_stim.txt", stim_mem);
        load_expected();
        repeat (10) @(posedge clk);
        reset_i <= 1'b0;
        repeat (3) @(posedge clk);
        run_stimulus();
        wait_pipeline_empty(50, "the last alpha step");
        if (exp_b1.size() != 0 || exp_b2.size() != 0 || exp_alpha.size() != 0 ||
            exp_end.size() != 0) begin
            stop_on_error("stim file holds expected values that no pair produced");
        end else begin
            $display("Test OK");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- source/alpha_recursion.sv
`timescale 1ns/10ps
`default_nettype none

module alpha_recursion (
    input  wire logic               clk,
    input  wire logic               reset_i,
    input  wire turbo_pkg::metric_t branch1_i,
    input  wire turbo_pkg::metric_t branch2_i,
    input  wire logic               branch_valid_i,
    input  wire turbo_pkg::blklen_t blklen_i,
    output turbo_pkg::metric_t      alpha0_o,
    output turbo_pkg::metric_t      alpha1_o,
    output turbo_pkg::metric_t      alpha2_o,
    output turbo_pkg::metric_t      alpha3_o,
    output turbo_pkg::metric_t      alpha4_o,
    output turbo_pkg::metric_t      alpha5_o,
    output turbo_pkg::metric_t      alpha6_o,
    output turbo_pkg::metric_t      alpha7_o,
    output logic                    alpha_valid_o,
    output logic                    block_end_o
);

    turbo_pkg::metric_t alpha_q [turbo_pkg::N_STATES];
    turbo_pkg::metric_t acs_c   [turbo_pkg::N_STATES];
    turbo_pkg::metric_t norm_c  [turbo_pkg::N_STATES];
    turbo_pkg::blklen_t step_q;
    logic               last_step;

    // signed max, first candidate wins a tie
    function automatic turbo_pkg::metric_t acs_max(
        input turbo_pkg::metric_t first,
        input turbo_pkg::metric_t second
    );
        if ($signed(first) >= $signed(second)) begin
            return first;
        end
        return second;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // add-compare-select
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        acs_c[0] = acs_max(alpha_q[0] + branch1_i, alpha_q[1] - branch1_i);
        acs_c[1] = acs_max(alpha_q[3] + branch2_i, alpha_q[2] - branch2_i);
        acs_c[2] = acs_max(alpha_q[4] + branch2_i, alpha_q[5] - branch2_i);
        acs_c[3] = acs_max(alpha_q[7] + branch1_i, alpha_q[6] - branch1_i);
        acs_c[4] = acs_max(alpha_q[1] + branch1_i, alpha_q[0] - branch1_i);
        acs_c[5] = acs_max(alpha_q[2] + branch2_i, alpha_q[3] - branch2_i);
        acs_c[6] = acs_max(alpha_q[5] + branch2_i, alpha_q[4] - branch2_i);
        acs_c[7] = acs_max(alpha_q[6] + branch1_i, alpha_q[7] - branch1_i);
        // normalize against new state 0
        for (int s = 0; s < turbo_pkg::N_STATES; s++) begin
            norm_c[s] = acs_c[s] - acs_c[0];
        end
    end

    assign last_step = (step_q + 16'd1) == blklen_i;

    //////////////////////////////////////////////////////////////////////
    // state metrics and block counter
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset_i) begin
            step_q        <= '0;
            alpha_valid_o <= 1'b0;
            block_end_o   <= 1'b0;
            alpha_q[0]    <= '0;
            for (int s = 1; s < turbo_pkg::N_STATES; s++) begin
                alpha_q[s] <= turbo_pkg::INIT_METRIC;
            end
        end else begin
            alpha_valid_o <= branch_valid_i;
            block_end_o   <= branch_valid_i && last_step;
            if (branch_valid_i) begin
                if (last_step) begin
                    // next block starts from known state 0
                    step_q     <= '0;
                    alpha_q[0] <= '0;
                    for (int s = 1; s < turbo_pkg::N_STATES; s++) begin
                        alpha_q[s] <= turbo_pkg::INIT_METRIC;
                    end
                end else begin
                    step_q  <= step_q + 16'd1;
                    alpha_q <= norm_c;
                end
            end
        end
    end

    // debug view of each step
    always_ff @(posedge clk) begin
        if (branch_valid_i) begin
            alpha0_o <= norm_c[0];
            alpha1_o <= norm_c[1];
            alpha2_o <= norm_c[2];
            alpha3_o <= norm_c[3];
            alpha4_o <= norm_c[4];
            alpha5_o <= norm_c[5];
            alpha6_o <= norm_c[6];
            alpha7_o <= norm_c[7];
        end
    end

endmodule

`default_nettype wire

//--- source/branch_metric.sv
`timescale 1ns/10ps
`default_nettype none

module branch_metric (
    input  wire logic               clk,
    input  wire logic               reset_i,
    input  wire turbo_pkg::metric_t sys_i,
    input  wire turbo_pkg::metric_t parity_i,
    input  wire logic               pair_valid_i,
    input  wire turbo_pkg::metric_t apriori_i,
    input  wire logic               valid_apriori_i,
    output turbo_pkg::metric_t      branch1_o,
    output turbo_pkg::metric_t      branch2_o,
    output logic                    branch_valid_o
);

    turbo_pkg::metric_t apriori_q;
    turbo_pkg::metric_t sys_apr;

    // a new a-priori word only affects pairs after this edge
    always_ff @(posedge clk) begin
        if (reset_i) begin
            apriori_q      <= '0;
            branch_valid_o <= 1'b0;
        end else begin
            branch_valid_o <= pair_valid_i;
            if (valid_apriori_i) begin
                apriori_q <= apriori_i;
            end
        end
    end

    assign sys_apr = sys_i + apriori_q;

    always_ff @(posedge clk) begin
        if (pair_valid_i) begin
            branch1_o <= sys_apr + parity_i;
            branch2_o <= sys_apr - parity_i;
        end
    end

endmodule

`default_nettype wire

//--- source/sys_parity_split.sv
`timescale 1ns/10ps
`default_nettype none

module sys_parity_split (
    input  wire logic               clk,
    input  wire logic               reset_i,
    input  wire turbo_pkg::metric_t data_i,
    input  wire logic               valid_i,
    output turbo_pkg::metric_t      sys_o,
    output turbo_pkg::metric_t      parity_o,
    output logic                    pair_valid_o
);

    turbo_pkg::pair_state_t state_q;
    turbo_pkg::metric_t     sys_hold_q;
    logic                   take_sys;
    logic                   take_parity;

    assign take_sys    = valid_i && (state_q == turbo_pkg::WAIT_SYS);
    assign take_parity = valid_i && (state_q == turbo_pkg::WAIT_PARITY);

    // even words are systematic, odd words parity
    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q      <= turbo_pkg::WAIT_SYS;
            pair_valid_o <= 1'b0;
        end else begin
            pair_valid_o <= take_parity;
            if (take_sys) begin
                state_q <= turbo_pkg::WAIT_PARITY;
            end else if (take_parity) begin
                state_q <= turbo_pkg::WAIT_SYS;
            end
        end
    end

    // word storage
    always_ff @(posedge clk) begin
        if (take_sys) begin
            sys_hold_q <= data_i;
        end
        if (take_parity) begin
            sys_o    <= sys_hold_q;
            parity_o <= data_i;
        end
    end

endmodule

`default_nettype wire

//--- source/turbo_alpha_top.sv
`timescale 1ns/10ps
`default_nettype none

module turbo_alpha_top (
    input  wire logic               clk,
    input  wire logic               reset_i,
    input  wire turbo_pkg::metric_t data_i,
    input  wire logic               valid_i,
    input  wire turbo_pkg::metric_t apriori_i,
    input  wire logic               valid_apriori_i,
    input  wire turbo_pkg::blklen_t blklen_i,
    output turbo_pkg::metric_t      branch1_o,
    output turbo_pkg::metric_t      branch2_o,
    output logic                    branch_valid_o,
    output turbo_pkg::metric_t      alpha0_o,
    output turbo_pkg::metric_t      alpha1_o,
    output turbo_pkg::metric_t      alpha2_o,
    output turbo_pkg::metric_t      alpha3_o,
    output turbo_pkg::metric_t      alpha4_o,
    output turbo_pkg::metric_t      alpha5_o,
    output turbo_pkg::metric_t      alpha6_o,
    output turbo_pkg::metric_t      alpha7_o,
    output logic                    alpha_valid_o,
    output logic                    block_end_o
);

    turbo_pkg::metric_t sys;
    turbo_pkg::metric_t parity;
    logic               pair_valid;

    //////////////////////////////////////////////////////////////////////
    // input pairing and branch metrics
    //////////////////////////////////////////////////////////////////////

    sys_parity_split sys_parity_split_inst (
        .clk            (clk),
        .reset_i        (reset_i),
        .data_i         (data_i),
        .valid_i        (valid_i),
        .sys_o          (sys),
        .parity_o       (parity),
        .pair_valid_o   (pair_valid)
    );

    branch_metric branch_metric_inst (
        .clk             (clk),
        .reset_i         (reset_i),
        .sys_i           (sys),
        .parity_i        (parity),
        .pair_valid_i    (pair_valid),
        .apriori_i       (apriori_i),
        .valid_apriori_i (valid_apriori_i),
        .branch1_o       (branch1_o),
        .branch2_o       (branch2_o),
        .branch_valid_o  (branch_valid_o)
    );

    //////////////////////////////////////////////////////////////////////
    // forward recursion
    //////////////////////////////////////////////////////////////////////

    alpha_recursion alpha_recursion_inst (
        .clk            (clk),
        .reset_i        (reset_i),
        .branch1_i      (branch1_o),
        .branch2_i      (branch2_o),
        .branch_valid_i (branch_valid_o),
        .blklen_i       (blklen_i),
        .alpha0_o       (alpha0_o),
        .alpha1_o       (alpha1_o),
        .alpha2_o       (alpha2_o),
        .alpha3_o       (alpha3_o),
        .alpha4_o       (alpha4_o),
        .alpha5_o       (alpha5_o),
        .alpha6_o       (alpha6_o),
        .alpha7_o       (alpha7_o),
        .alpha_valid_o  (alpha_valid_o),
        .block_end_o    (block_end_o)
    );

endmodule

`default_nettype wire

//--- source/turbo_pkg.sv
`default_nettype none

package turbo_pkg;

    //////////////////////////////////////////////////////////////////////
    // metric and length types
    //////////////////////////////////////////////////////////////////////

    // signed two's-complement soft value, sums wrap at 16 bits
    typedef logic [15:0] metric_t;

    // trellis steps per block
    typedef logic [15:0] blklen_t;

    //////////////////////////////////////////////////////////////////////
    // trellis
    //////////////////////////////////////////////////////////////////////

    localparam int N_STATES = 8;

    // start metric of states 1..7, state 0 starts at 0
    localparam metric_t INIT_METRIC = metric_t'(-128);

    // sys/parity pairing
    typedef enum logic {
        WAIT_SYS,
        WAIT_PARITY
    } pair_state_t;

endpackage

`default_nettype wire
